//--- files.f
design/vit_code_pkg.sv
design/vit_ctrl_pkg.sv
design/vit_control.sv
design/branch_metric.sv
design/add_compare_select.sv
design/survivor_memory.sv
design/traceback.sv
design/viterbi_decoder.sv
verification/tb_viterbi.sv

//--- run.sh
#!/bin/sh
# build and run the Viterbi decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_viterbi

# the simulator exit status is not trusted, the pass line decides
out=$(./obj_dir/Vtb_viterbi 2>&1) || true
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

//--- verification/tb_viterbi.sv
`timescale 1ns/10ps

module tb_viterbi;

    localparam int FRAME_LEN = 32;
    localparam int MSG_W = FRAME_LEN - 2;
    localparam int NUM_ROWS = 11;
    localparam int NUM_FIXED = 7;

    logic                 clk;
    logic                 rst;
    logic                 i_en;
    logic                 i_start;
    logic [1:0]           i_sym;
    logic                 o_busy;
    logic                 o_done;
    logic [FRAME_LEN-1:0] o_data;

    // stimulus table of message, error mask, stall length per phase and expected frame
    logic [FRAME_LEN-3:0]   tbl_msg  [NUM_ROWS];
    logic [2*FRAME_LEN-1:0] tbl_mask [NUM_ROWS];
    int                     tbl_gap  [NUM_ROWS];
    logic [FRAME_LEN-1:0]   tbl_exp  [NUM_ROWS];

    integer seed;
    int     cycles;
    int     cycle_limit;
    int     checks_done;

    viterbi_decoder #(.FRAME_LEN(FRAME_LEN)) i_dut (
        .clk(clk), .rst(rst), .i_en(i_en), .i_start(i_start), .i_sym(i_sym),
        .o_busy(o_busy), .o_done(o_done), .o_data(o_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // rate 1/2 reference encoder with taps 7 and 5 octal on {u[k], u[k-1], u[k-2]}
    function automatic logic [2*FRAME_LEN-1:0] encode_frame(input logic [FRAME_LEN-1:0] bits);
        logic [2:0]             sr;
        logic [2*FRAME_LEN-1:0] syms;
        sr = 3'b000;
        for (int k = 0; k < FRAME_LEN; k++)
        begin
            sr = {bits[k], sr[2], sr[1]};
            syms[2*k+1] = sr[2] ^ sr[1] ^ sr[0];   // generator 7 gives the first code bit
            syms[2*k]   = sr[2] ^ sr[0];           // generator 5
        end
        return syms;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks_done++;
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s = 0x%h, expected 0x%h",
                     $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic set_row(input int r, input logic [FRAME_LEN-3:0] msg,
                           input logic [2*FRAME_LEN-1:0] mask, input int gap);
        tbl_msg[r]  = msg;
        tbl_mask[r] = mask;
        tbl_gap[r]  = gap;
        tbl_exp[r]  = {2'b00, msg};    // two zero tail bits on top
    endtask

    task automatic load_table();
        int pos;
        set_row(0, 30'h1234_5678, 64'd0, 0);
        set_row(1, 30'h0000_0000, 64'd0, 0);             // all zero
        set_row(2, 30'h3fff_ffff, 64'd0, 0);             // all one
        set_row(3, 30'h2aaa_5555, 64'd1 << 17, 0);       // single flip
        set_row(4, 30'h1f0f_3c96, (64'd1 << 5) | (64'd1 << 40), 0);
        set_row(5, 30'h0bad_cafe, 64'd0, 3);             // stalls only
        set_row(6, 30'h3c3c_0f0f, (64'd1 << 0) | (64'd1 << 63), 1);
        for (int r = NUM_FIXED; r < NUM_ROWS; r++)
        begin
            pos = {$random(seed)} % (2 * FRAME_LEN);
            // even random rows are error free
            set_row(r, MSG_W'($random(seed)), (r % 2 == 0) ? 64'd0 : 64'd1 << pos,
                    {$random(seed)} % 3);
        end
    endtask

    // chained_in means the current edge already sampled i_start
    task automatic run_frame(input int row, input bit chained_in, input bit chain_out);
        logic [2*FRAME_LEN-1:0] syms;
        int ec;
        int edges;
        int stall_left;
        bit en_seen;
        bit done_seen;
        syms = encode_frame({2'b00, tbl_msg[row]}) ^ tbl_mask[row];
        ec = 0;
        edges = 0;
        stall_left = 0;
        done_seen = 1'b0;
        if (!chained_in)
        begin
            @(posedge clk);
            i_start <= 1'b1;
            i_en    <= 1'b1;
            @(posedge clk);
        end
        i_start <= 1'b0;
        i_en    <= 1'b1;
        i_sym   <= syms[1:0];
        while (!done_seen)
        begin
            @(posedge clk);
            edges++;
            en_seen   = i_en;      // value the DUT just sampled
            done_seen = o_done;
            if (en_seen)
                ec++;
            if (!done_seen)
            begin
                check_value("o_busy", 64'(o_busy), 64'd1);
                // stall once in forward, drain and back phase
                if (en_seen && (ec == FRAME_LEN / 2 || ec == FRAME_LEN ||
                                ec == FRAME_LEN + FRAME_LEN / 2))
                    stall_left = tbl_gap[row];
                if (stall_left > 0)
                begin
                    i_en <= 1'b0;
                    stall_left--;
                end
                else
                begin
                    i_en <= 1'b1;
                end
                if (ec < FRAME_LEN)
                    i_sym <= syms[2*ec +: 2];
                // next start lands in the done cycle
                i_start <= chain_out && en_seen && (ec == 2 * FRAME_LEN + 1);
            end
        end
        check_value("o_done delay", 64'(edges), 64'(2 * FRAME_LEN + 2 + 3 * tbl_gap[row]));
        check_value("o_data", 64'(o_data), 64'(tbl_exp[row]));
        check_value("o_busy", 64'(o_busy), 64'd0);
    endtask

    initial
    begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("TIMEOUT: the decoder never finished, %0d cycles used", cycles);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    end

    initial
    begin
        rst = 1'b0;
        i_en = 1'b0;
        i_start = 1'b0;
        i_sym = 2'b00;
        seed = 32'h2e43_9a8d;
        cycles = 0;
        checks_done = 0;
        load_table();
        cycle_limit = FRAME_LEN / 2 + 8 + 64;   // reset test plus margin
        for (int r = 0; r < NUM_ROWS; r++)
            cycle_limit += 2 * FRAME_LEN + 3 + 3 * tbl_gap[r];
        repeat (2) @(posedge clk);
        rst  <= 1'b1;
        i_en <= 1'b1;

        // whole table back to back
        for (int r = 0; r < NUM_ROWS; r++)
            run_frame(r, r > 0, r < NUM_ROWS - 1);

        // reset in the middle of the forward phase
        @(posedge clk);
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        repeat (FRAME_LEN / 2) @(posedge clk);
        check_value("o_busy", 64'(o_busy), 64'd1);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        check_value("o_busy", 64'(o_busy), 64'd0);
        check_value("o_done", 64'(o_done), 64'd0);
        rst <= 1'b1;
        run_frame(3, 1'b0, 1'b0);    // decoder recovers

        $display("%0d checks done in %0d cycles", checks_done, cycles);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- design/viterbi_decoder.sv
`timescale 1ns/10ps

module viterbi_decoder #(
    parameter int FRAME_LEN = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_en,
    input  logic                 i_start,
    input  logic [1:0]           i_sym,      // {GEN_A bit, GEN_B bit}
    output logic                 o_busy,
    output logic                 o_done,
    output logic [FRAME_LEN-1:0] o_data      // bit 0 is the first message bit
);

    localparam int ADDR_W = $clog2(FRAME_LEN);

    logic                                en_bm;
    logic                                en_acs;
    logic                                en_tb;
    logic                                tb_first;
    logic [ADDR_W-1:0]                   wr_addr;
    logic [ADDR_W-1:0]                   rd_addr;
    logic [vit_code_pkg::BM_W-1:0]       bm0;
    logic [vit_code_pkg::BM_W-1:0]       bm1;
    logic [vit_code_pkg::BM_W-1:0]       bm2;
    logic [vit_code_pkg::BM_W-1:0]       bm3;
    logic [vit_code_pkg::NUM_STATES-1:0] dec;
    logic                                dec_valid;
    logic [vit_code_pkg::NUM_STATES-1:0] rd_dec;

    vit_control #(.FRAME_LEN(FRAME_LEN)) u_control (
        .clk(clk), .rst(rst), .i_en(i_en), .i_start(i_start),
        .o_busy(o_busy), .o_en_bm(en_bm), .o_en_acs(en_acs),
        .o_en_tb(en_tb), .o_tb_first(tb_first),
        .o_wr_addr(wr_addr), .o_rd_addr(rd_addr), .o_done(o_done)
    );

    branch_metric u_bm (
        .clk(clk), .rst(rst), .i_en(i_en), .i_en_bm(en_bm), .i_sym(i_sym),
        .o_bm0(bm0), .o_bm1(bm1), .o_bm2(bm2), .o_bm3(bm3)
    );

    // first bm cycle seeds the path metrics
    add_compare_select u_acs (
        .clk(clk), .rst(rst), .i_en(i_en), .i_en_acs(en_acs), .i_first(en_bm),
        .i_bm0(bm0), .i_bm1(bm1), .i_bm2(bm2), .i_bm3(bm3),
        .o_dec(dec), .o_dec_valid(dec_valid)
    );

    survivor_memory #(.FRAME_LEN(FRAME_LEN)) u_surv (
        .clk(clk), .rst(rst), .i_en(i_en), .i_wr(dec_valid),
        .i_wr_addr(wr_addr), .i_dec(dec),
        .i_rd_addr(rd_addr), .o_rd_dec(rd_dec)
    );

    traceback #(.FRAME_LEN(FRAME_LEN)) u_tb (
        .clk(clk), .rst(rst), .i_en(i_en), .i_en_tb(en_tb), .i_first(tb_first),
        .i_rd_addr(rd_addr), .i_rd_dec(rd_dec), .o_data(o_data)
    );

endmodule

//--- design/traceback.sv
`timescale 1ns/10ps

module traceback #(
    parameter int FRAME_LEN = 32
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_en,
    input  logic                                i_en_tb,
    input  logic                                i_first,
    input  logic [$clog2(FRAME_LEN)-1:0]        i_rd_addr,
    input  logic [vit_code_pkg::NUM_STATES-1:0] i_rd_dec,
    output logic [FRAME_LEN-1:0]                o_data
);

    logic [vit_code_pkg::STATE_W-1:0] tb_state;
    logic [vit_code_pkg::STATE_W-1:0] cur_state;
    logic [FRAME_LEN-1:0]             frame;
    logic                             dec_bit;
    logic                             out_bit;
    logic                             last_step;

    // tail bits force the walk to begin in state 0
    assign cur_state = i_first ? '0 : tb_state;
    assign dec_bit   = i_rd_dec[cur_state];
    assign out_bit   = cur_state[vit_code_pkg::STATE_W-1];    // newest input bit
    assign last_step = (i_rd_addr == '0);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            tb_state <= '0;
        else if (i_en && i_en_tb)
            tb_state <= {cur_state[vit_code_pkg::STATE_W-2:0], dec_bit};  // predecessor
    end

    // working frame, filled from the top down
    always_ff @(posedge clk)
    begin
        if (i_en && i_en_tb)
            frame[i_rd_addr] <= out_bit;
    end

    // published in one go so the output stays stable between frames
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            o_data <= '0;
        else if (i_en && i_en_tb && last_step)
            o_data <= {frame[FRAME_LEN-1:1], out_bit};
    end

endmodule

//--- design/survivor_memory.sv
`timescale 1ns/10ps

module survivor_memory #(
    parameter int FRAME_LEN = 32
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_en,
    input  logic                                i_wr,
    input  logic [$clog2(FRAME_LEN)-1:0]        i_wr_addr,
    input  logic [vit_code_pkg::NUM_STATES-1:0] i_dec,
    input  logic [$clog2(FRAME_LEN)-1:0]        i_rd_addr,
    output logic [vit_code_pkg::NUM_STATES-1:0] o_rd_dec
);

    // one decision word per trellis step
    logic [vit_code_pkg::NUM_STATES-1:0] mem [FRAME_LEN];

    always_ff @(posedge clk)
    begin
        if (i_en && i_wr)
            mem[i_wr_addr] <= i_dec;
    end

    assign o_rd_dec = mem[i_rd_addr];   // async read for traceback

    a_wr_in_range: assert property (@(posedge clk) disable iff (!rst)
        (i_en && i_wr) |-> (int'(i_wr_addr) < FRAME_LEN));

endmodule

//--- design/add_compare_select.sv
`timescale 1ns/10ps

module add_compare_select (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_en,
    input  logic                                i_en_acs,
    input  logic                                i_first,
    input  logic [vit_code_pkg::BM_W-1:0]       i_bm0,
    input  logic [vit_code_pkg::BM_W-1:0]       i_bm1,
    input  logic [vit_code_pkg::BM_W-1:0]       i_bm2,
    input  logic [vit_code_pkg::BM_W-1:0]       i_bm3,
    output logic [vit_code_pkg::NUM_STATES-1:0] o_dec,
    output logic                                o_dec_valid
);

    logic [vit_code_pkg::PM_W-1:0] pm     [vit_code_pkg::NUM_STATES];
    logic [vit_code_pkg::PM_W-1:0] pm_nxt [vit_code_pkg::NUM_STATES];
    logic [vit_code_pkg::BM_W-1:0] bm     [vit_code_pkg::NUM_STATES];

    // encoder output for shift register contents {u, s[1], s[0]}
    function automatic logic [1:0] code_sym(
        input logic [vit_code_pkg::CONSTRAINT_LEN-1:0] sr
    );
        code_sym = {^(sr & vit_code_pkg::GEN_A), ^(sr & vit_code_pkg::GEN_B)};
    endfunction

    assign bm[0] = i_bm0;
    assign bm[1] = i_bm1;
    assign bm[2] = i_bm2;
    assign bm[3] = i_bm3;

    // state ns = {u, b} is reached from {b, 0} and {b, 1}
    always_comb
    begin
        logic [vit_code_pkg::STATE_W-1:0] ns;
        logic [vit_code_pkg::STATE_W-1:0] p0;
        logic [vit_code_pkg::STATE_W-1:0] p1;
        logic [vit_code_pkg::PM_W-1:0]    c0;
        logic [vit_code_pkg::PM_W-1:0]    c1;
        for (int s = 0; s < vit_code_pkg::NUM_STATES; s++)
        begin
            ns = vit_code_pkg::STATE_W'(s);
            p0 = {ns[0], 1'b0};
            p1 = {ns[0], 1'b1};
            c0 = pm[p0] + vit_code_pkg::PM_W'(bm[code_sym({ns[1], p0})]);
            c1 = pm[p1] + vit_code_pkg::PM_W'(bm[code_sym({ns[1], p1})]);
            o_dec[s]  = (c1 < c0);     // tie keeps p0
            pm_nxt[s] = (c1 < c0) ? c1 : c0;
        end
    end

    assign o_dec_valid = i_en_acs;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int s = 0; s < vit_code_pkg::NUM_STATES; s++)
                pm[s] <= '0;
        end
        else if (i_en)
        begin
            if (i_en_acs)
            begin
                pm <= pm_nxt;
            end
            else if (i_first)
            begin
                // first bm cycle, encoder known to start in state 0
                for (int s = 0; s < vit_code_pkg::NUM_STATES; s++)
                    pm[s] <= (s == 0) ? '0 : vit_code_pkg::PM_INIT_BIAS;
            end
        end
    end

    for (genvar g = 0; g < vit_code_pkg::NUM_STATES; g++)
    begin : g_pm_chk
        a_pm_no_sat: assert property (@(posedge clk) disable iff (!rst)
            (i_en && i_en_acs) |=> (pm[g] != '1));
    end

endmodule

//--- design/branch_metric.sv
`timescale 1ns/10ps

module branch_metric (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_en,
    input  logic                          i_en_bm,
    input  logic [1:0]                    i_sym,
    output logic [vit_code_pkg::BM_W-1:0] o_bm0,
    output logic [vit_code_pkg::BM_W-1:0] o_bm1,
    output logic [vit_code_pkg::BM_W-1:0] o_bm2,
    output logic [vit_code_pkg::BM_W-1:0] o_bm3
);

    // hard decision distance between two code symbols
    function automatic logic [vit_code_pkg::BM_W-1:0] hamming(
        input logic [1:0] a,
        input logic [1:0] b
    );
        logic [1:0] diff;
        diff = a ^ b;
        hamming = vit_code_pkg::BM_W'(diff[1]) + vit_code_pkg::BM_W'(diff[0]);
    endfunction

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            o_bm0 <= '0;
            o_bm1 <= '0;
            o_bm2 <= '0;
            o_bm3 <= '0;
        end
        else if (i_en && i_en_bm)
        begin
            // o_bmN is the distance to code symbol N
            o_bm0 <= hamming(i_sym, 2'd0);
            o_bm1 <= hamming(i_sym, 2'd1);
            o_bm2 <= hamming(i_sym, 2'd2);
            o_bm3 <= hamming(i_sym, 2'd3);
        end
    end

endmodule

//--- design/vit_control.sv
`timescale 1ns/10ps

module vit_control #(
    parameter int FRAME_LEN = 32
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_en,
    input  logic                         i_start,
    output logic                         o_busy,
    output logic                         o_en_bm,
    output logic                         o_en_acs,
    output logic                         o_en_tb,
    output logic                         o_tb_first,
    output logic [$clog2(FRAME_LEN)-1:0] o_wr_addr,
    output logic [$clog2(FRAME_LEN)-1:0] o_rd_addr,
    output logic                         o_done
);

    localparam int ADDR_W = $clog2(FRAME_LEN);
    localparam int CNT_W = $clog2(FRAME_LEN + 1);   // drain step reaches FRAME_LEN

    logic [vit_ctrl_pkg::PHASE_W-1:0] phase;
    logic [CNT_W-1:0]                 cnt;
    logic                             last_step;
    logic                             done;

    assign last_step = (cnt == CNT_W'(FRAME_LEN - 1));

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            phase <= vit_ctrl_pkg::PH_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end
        else if (i_en)
        begin
            done <= 1'b0;
            case (phase)
                vit_ctrl_pkg::PH_IDLE:
                begin
                    cnt <= '0;
                    if (i_start)
                        phase <= vit_ctrl_pkg::PH_FORWARD;
                end
                vit_ctrl_pkg::PH_FORWARD:
                begin
                    cnt <= cnt + 1'b1;  // runs on into drain
                    if (last_step)
                        phase <= vit_ctrl_pkg::PH_DRAIN;
                end
                vit_ctrl_pkg::PH_DRAIN:
                begin
                    cnt   <= '0;
                    phase <= vit_ctrl_pkg::PH_BACK;
                end
                default:
                begin
                    if (last_step)
                    begin
                        cnt   <= '0;
                        done  <= 1'b1;
                        phase <= vit_ctrl_pkg::PH_IDLE;
                    end
                    else
                    begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign o_busy   = (phase != vit_ctrl_pkg::PH_IDLE);
    assign o_en_bm  = (phase == vit_ctrl_pkg::PH_FORWARD);
    // acs trails bm by one step
    assign o_en_acs = ((phase == vit_ctrl_pkg::PH_FORWARD) && (cnt != '0)) ||
                      (phase == vit_ctrl_pkg::PH_DRAIN);
    assign o_wr_addr = ADDR_W'(cnt - 1'b1);
    assign o_en_tb    = (phase == vit_ctrl_pkg::PH_BACK);
    assign o_tb_first = (phase == vit_ctrl_pkg::PH_BACK) && (cnt == '0);
    assign o_rd_addr  = ADDR_W'(CNT_W'(FRAME_LEN - 1) - cnt);   // newest step first
    assign o_done = done;

    a_bm_tb_excl: assert property (@(posedge clk) disable iff (!rst)
        !(o_en_bm && o_en_tb));

endmodule

//--- design/vit_ctrl_pkg.sv
package vit_ctrl_pkg;

    localparam int PHASE_W = 2;

    // controller phases
    localparam logic [PHASE_W-1:0] PH_IDLE    = 2'd0;
    localparam logic [PHASE_W-1:0] PH_FORWARD = 2'd1;  // symbols in, bm + acs
    localparam logic [PHASE_W-1:0] PH_DRAIN   = 2'd2;  // last acs step
    localparam logic [PHASE_W-1:0] PH_BACK    = 2'd3;  // traceback walk

endpackage

//--- design/vit_code_pkg.sv
package vit_code_pkg;

    // rate 1/2, K=3 code, generators 7 and 5 octal
    localparam int CONSTRAINT_LEN = 3;
    localparam int NUM_STATES = 4;
    localparam int STATE_W = 2;     // state = {newest bit, older bit}

    // generator taps line up with {u, s[1], s[0]}
    localparam logic [CONSTRAINT_LEN-1:0] GEN_A = 3'o7;     // first code bit, i_sym[1]
    localparam logic [CONSTRAINT_LEN-1:0] GEN_B = 3'o5;     // second code bit, i_sym[0]

    // path metrics
    localparam int PM_W = 8;
    localparam int BM_W = 2;        // hamming distance 0..2

    // keeps the survivor path rooted in state 0
    localparam logic [PM_W-1:0] PM_INIT_BIAS = 8'd32;

endpackage
